// ==== all.f ====
rv_pkg.sv
pc_unit.sv
inst_mem.sv
decoder.sv
reg_file.sv
alu.sv
data_mem.sv
rv_core.sv
rv_assertions.sv
rv_tb.sv

// ==== alu.sv ====
`timescale 1ns/1ns

module alu
  import rv_pkg::*;
(
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  alu_op_e         alu_op,
  input  logic            branch,
  input  logic [2:0]      funct3,
  output logic [xlen-1:0] result,
  output logic            take_branch
);

  logic [xlen:0]   diff;
  logic [xlen-1:0] sub;
  logic [4:0]      shamt;
  logic            z;
  logic            v;
  logic            c;
  logic            s;
  logic            cond;

  // a + ~b + 1, carry out set means no borrow
  assign diff  = {1'b0, a} + {1'b0, ~b} + 33'd1;
  assign sub   = diff[xlen-1:0];
  assign shamt = b[4:0];

  // flags of a - b
  assign z = (sub == '0);
  assign c = diff[xlen];
  assign s = sub[xlen-1];
  assign v = (a[xlen-1] ^ b[xlen-1]) & (a[xlen-1] ^ sub[xlen-1]);

  always_comb begin
    case (alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = sub;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      // signed less-than is s xor v
      alu_slt:    result = {31'b0, s ^ v};
      // borrow means a below b unsigned
      alu_sltu:   result = {31'b0, ~c};
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  cond = z;
      3'b001:  cond = ~z;
      3'b100:  cond = s ^ v;
      3'b101:  cond = ~(s ^ v);
      3'b110:  cond = ~c;
      3'b111:  cond = c;
      default: cond = 1'b0;
    endcase
  end

  assign take_branch = branch & cond;

endmodule

// ==== data_mem.sv ====
`timescale 1ns/1ns

module data_mem
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            we,
  input  logic            re,
  input  logic            byte_access,
  input  logic            unsigned_load,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rdata
);

  logic [xlen-1:0] mem [dmem_words];
  logic [5:0]      idx;
  logic [4:0]      lane_lsb;
  logic [xlen-1:0] word;
  logic [7:0]      rbyte;

  // word index and bit offset of the selected byte lane
  assign idx      = addr[7:2];
  assign lane_lsb = {addr[1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (we) begin
      if (byte_access) begin
        mem[idx][lane_lsb +: 8] <= wdata[7:0];
      end else begin
        mem[idx] <= wdata;
      end
    end
  end

  assign word  = mem[idx];
  assign rbyte = word[lane_lsb +: 8];

  // lb sign extends, lbu zero extends
  always_comb begin
    if (!re) begin
      rdata = '0;
    end else if (byte_access) begin
      rdata = unsigned_load ? {24'b0, rbyte} : {{24{rbyte[7]}}, rbyte};
    end else begin
      rdata = word;
    end
  end

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ns

module decoder
  import rv_pkg::*;
(
  input  inst_u           inst,
  output ctrl_t           ctrl,
  output logic [xlen-1:0] imm
);

  // funct3 to alu selection for register and immediate forms
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic f7b5,
                                      input logic reg_form);
    alu_op_e sel;
    case (f3)
      // sub only exists in the register form
      3'b000:  sel = (reg_form && f7b5) ? alu_sub : alu_add;
      3'b001:  sel = alu_sll;
      3'b010:  sel = alu_slt;
      3'b011:  sel = alu_sltu;
      3'b100:  sel = alu_xor;
      // bit 30 picks the arithmetic shift for sra and srai
      3'b101:  sel = f7b5 ? alu_sra : alu_srl;
      3'b110:  sel = alu_or;
      default: sel = alu_and;
    endcase
    return sel;
  endfunction

  // sign-extended immediate of each format
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
  assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
  assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                  inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    // defaults keep unknown opcodes harmless
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.wb_sel = wb_alu;
    imm         = '0;
    case (inst.r_fmt.opcode)
      op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_sel(inst.r_fmt.funct3, inst.r_fmt.funct7[5], 1'b1);
      end
      op_imm: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_sel(inst.i_fmt.funct3, inst.r_fmt.funct7[5], 1'b0);
        imm              = imm_i;
      end
      op_lui: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_pass_b;
        imm              = imm_u;
      end
      op_auipc: begin
        // pc + upper immediate through the adder
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_src_pc  = 1'b1;
        imm              = imm_u;
      end
      op_load: begin
        ctrl.reg_write    = 1'b1;
        ctrl.mem_read     = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.mem_byte     = (inst.i_fmt.funct3[1:0] == 2'b00);
        ctrl.mem_unsigned = inst.i_fmt.funct3[2];
        ctrl.wb_sel       = wb_mem;
        imm               = imm_i;
      end
      op_store: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_byte    = (inst.s_fmt.funct3[1:0] == 2'b00);
        imm              = imm_s;
      end
      op_branch: begin
        // flags come from rs1 - rs2
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;
        imm         = imm_b;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = wb_pc4;
        imm            = imm_j;
      end
      op_jalr: begin
        ctrl.reg_write   = 1'b1;
        ctrl.jalr        = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel      = wb_pc4;
        imm              = imm_i;
      end
      default: begin
        // all enables stay low
      end
    endcase
  end

endmodule

// ==== inst_mem.sv ====
`timescale 1ns/1ns

module inst_mem
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            load_en,
  input  logic [5:0]      load_addr,
  input  logic [xlen-1:0] load_data,
  input  logic [xlen-1:0] pc,
  output inst_u           inst
);

  logic [xlen-1:0] mem [imem_words];
  logic [5:0]      rd_idx;

  // word index, byte offset bits dropped
  assign rd_idx = pc[7:2];

  // load port, one word per edge
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // asynchronous fetch
  assign inst = mem[rd_idx];

endmodule

// ==== pc_unit.sv ====
`timescale 1ns/1ns

module pc_unit
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            run,
  input  logic            take_branch,
  input  logic            jump,
  input  logic            jalr,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] alu_result,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] pc_plus4,
  output logic [xlen-1:0] next_pc
);

  // sequential successor, also the link value
  assign pc_plus4 = pc + 32'd4;

  // jalr target comes from rs1 + imm with bit 0 forced low
  always_comb begin
    if (jalr) begin
      next_pc = {alu_result[xlen-1:1], 1'b0};
    end else if (jump || take_branch) begin
      // jal and taken branches are pc relative
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // pc frozen while the program is being loaded
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc;
    end
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            we,
  input  logic [4:0]      ra1,
  input  logic [4:0]      ra2,
  input  logic [4:0]      wa,
  input  logic [xlen-1:0] wd,
  output logic [xlen-1:0] rd1,
  output logic [xlen-1:0] rd2
);

  logic [xlen-1:0] regs [32];

  // entry 0 is cleared by reset and never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  // combinational read ports
  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

endmodule

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module rv_tb -o rv_sim || exit 1
./obj_dir/rv_sim > sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// ==== rv_assertions.sv ====
`timescale 1ns/1ns

module rv_assertions
  import rv_pkg::*;
(
  input logic            clk,
  input logic            arst_n,
  input logic            run,
  input inst_u           inst,
  input logic [xlen-1:0] rs1_data,
  input logic [xlen-1:0] rs2_data,
  input retire_t         retire
);

  // sequential and jump targets stay on word boundaries
  next_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n) run |-> (retire.next_pc[1:0] == 2'b00)
  ) else $error("next_pc is not word aligned");

  // pc frozen while loading
  pc_held: assert property (
    @(posedge clk) disable iff (!arst_n) !run |=> $stable(retire.pc)
  ) else $error("pc moved while run was low");

  // x0 reads back as zero whatever was written to it
  x0_reads_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
      run |-> (((inst.r_fmt.rs1 != 5'd0) || (rs1_data == '0)) &&
               ((inst.r_fmt.rs2 != 5'd0) || (rs2_data == '0)))
  ) else $error("register x0 read back a nonzero value");

endmodule

bind rv_core rv_assertions rv_assertions_inst (
  .clk      (clk),
  .arst_n   (arst_n),
  .run      (run),
  .inst     (inst),
  .rs1_data (rs1_data),
  .rs2_data (rs2_data),
  .retire   (retire)
);

// ==== rv_core.sv ====
`timescale 1ns/1ns

module rv_core
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            run,
  input  logic            load_en,
  input  logic [5:0]      load_addr,
  input  logic [xlen-1:0] load_data,
  output retire_t         retire
);

  inst_u           inst;
  ctrl_t           ctrl;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] mem_rdata;
  logic [xlen-1:0] wb_data;
  logic            take_branch;
  logic            reg_we;
  logic            mem_we;

  // no state changes while run is low
  assign reg_we = run & ctrl.reg_write;
  assign mem_we = run & ctrl.mem_write;

  pc_unit pc_unit_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .run         (run),
    .take_branch (take_branch),
    .jump        (ctrl.jump),
    .jalr        (ctrl.jalr),
    .imm         (imm),
    .alu_result  (alu_result),
    .pc          (pc),
    .pc_plus4    (pc_plus4),
    .next_pc     (next_pc)
  );

  inst_mem inst_mem_inst (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .inst      (inst)
  );

  decoder decoder_inst (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  reg_file reg_file_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (reg_we),
    .ra1    (inst.r_fmt.rs1),
    .ra2    (inst.r_fmt.rs2),
    .wa     (inst.r_fmt.rd),
    .wd     (wb_data),
    .rd1    (rs1_data),
    .rd2    (rs2_data)
  );

  // operand selection, pc only for auipc
  assign alu_a = ctrl.alu_src_pc ? pc : rs1_data;
  assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

  alu alu_inst (
    .a           (alu_a),
    .b           (alu_b),
    .alu_op      (ctrl.alu_op),
    .branch      (ctrl.branch),
    .funct3      (inst.b_fmt.funct3),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  data_mem data_mem_inst (
    .clk           (clk),
    .we            (mem_we),
    .re            (ctrl.mem_read),
    .byte_access   (ctrl.mem_byte),
    .unsigned_load (ctrl.mem_unsigned),
    .addr          (alu_result),
    .wdata         (rs2_data),
    .rdata         (mem_rdata)
  );

  // write-back source
  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wb_data = mem_rdata;
      wb_pc4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // retire record of the current instruction
  always_comb begin
    retire.valid     = run;
    retire.pc        = pc;
    retire.rd        = inst.r_fmt.rd;
    // writes to x0 are discarded, so not reported
    retire.reg_write = ctrl.reg_write && (inst.r_fmt.rd != 5'd0);
    retire.wd        = wb_data;
    retire.next_pc   = next_pc;
  end

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

  // memory depths in 32-bit words
  localparam int imem_words = 64;
  localparam int dmem_words = 64;

  // datapath width
  localparam int xlen = 32;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    // lui passes the immediate straight through
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc4
  } wb_sel_e;

  // one view per instruction format, msb first
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_u;

  // decoder outputs, 16 bits
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    jump;
    logic    jalr;
    logic    alu_src_imm;
    logic    alu_src_pc;
    logic    mem_byte;
    logic    mem_unsigned;
    alu_op_e alu_op;
    wb_sel_e wb_sel;
  } ctrl_t;

  // one record per executed instruction, 103 bits
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic            reg_write;
    logic [xlen-1:0] wd;
    logic [xlen-1:0] next_pc;
  } retire_t;

endpackage

// ==== rv_tb.sv ====
`timescale 1ns/1ns

module rv_tb
  import rv_pkg::*;
();

  localparam int period = 100;
  localparam int num_tests = 4;
  // reset, load, run and hold of one test, with margin
  localparam int test_cycles = 120;
  localparam int prog_words = 48;
  localparam logic [31:0] final_pc = 32'd188;
  localparam logic [31:0] seed = 32'h5c8b_404a;

  logic            clk = 1'b0;
  logic            arst_n;
  logic            run;
  logic            load_en;
  logic [5:0]      load_addr;
  logic [xlen-1:0] load_data;
  retire_t         retire;

  // reference state
  logic [31:0] m_regs [32];
  logic [31:0] m_mem [dmem_words];
  logic [31:0] m_pc;
  logic [31:0] prog [imem_words];
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          test_errors;

  rv_core rv_core_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .retire    (retire)
  );

  always #(period / 2) clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // x31 is reserved for jalr
  function automatic logic [4:0] pick_rd();
    logic [31:0] r;
    r = rand_bits(5);
    return (r[4:0] == 5'd31) ? 5'd0 : r[4:0];
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // register, immediate or upper immediate operation
  function automatic logic [31:0] alu_inst();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    r = rand_bits(32);
    rd = pick_rd();
    f3 = r[2:0];
    // bit 30 only means something for sub and the right shifts
    alt = r[5] && ((f3 == 3'b000) || (f3 == 3'b101));
    if (r[4:3] == 2'd0) begin
      return {1'b0, alt, 5'b0, r[10:6], r[15:11], f3, rd, op_reg};
    end
    if (r[4:3] == 2'd2) begin
      return enc_u(r[31:12], rd, r[5] ? op_lui : op_auipc);
    end
    if (f3 == 3'b001) begin
      imm = {7'b0, r[20:16]};
    end else if (f3 == 3'b101) begin
      imm = {1'b0, alt, 5'b0, r[20:16]};
    end else begin
      imm = r[27:16];
    end
    return enc_i(imm, r[10:6], f3, rd, op_imm);
  endfunction

  // x0 based, offsets inside the first 8 words
  function automatic logic [31:0] mem_inst();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [11:0] woff;
    logic [11:0] boff;
    r = rand_bits(20);
    rd = pick_rd();
    woff = {7'b0, r[5:3], 2'b00};
    boff = {7'b0, r[12:8]};
    case (r[2:0])
      3'd0, 3'd1: return enc_i(woff, 5'd0, 3'b010, rd, op_load);
      3'd2:       return enc_i(boff, 5'd0, 3'b000, rd, op_load);
      3'd3:       return enc_i(boff, 5'd0, 3'b100, rd, op_load);
      3'd4, 3'd5: return enc_s(woff, r[17:13], 5'd0, 3'b010);
      default:    return enc_s(boff, r[17:13], 5'd0, 3'b000);
    endcase
  endfunction

  // forward branch, 2 to 5 words ahead
  function automatic logic [31:0] branch_inst(input int i);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rs2;
    int          tgt;
    r = rand_bits(16);
    f3 = r[2:0];
    if ((f3 == 3'b010) || (f3 == 3'b011)) begin
      f3 = f3 + 3'd2;
    end
    tgt = i + 2 + int'(r[4:3]);
    if (tgt > prog_words - 1) begin
      tgt = prog_words - 1;
    end
    // equal operands now and then so beq and bge see the z flag
    rs2 = r[15] ? r[9:5] : r[14:10];
    return enc_b(13'((tgt - i) * 4), rs2, r[9:5], f3);
  endfunction

  function automatic logic [31:0] jump_inst(input int i);
    logic [31:0] r;
    logic [4:0]  rd;
    int          k;
    int          tgt;
    r = rand_bits(4);
    rd = pick_rd();
    k = int'(r[3:1]);
    if (r[0]) begin
      tgt = i + 1 + k;
      if (tgt > prog_words - 1) begin
        tgt = prog_words - 1;
      end
      return enc_j(21'((tgt - i) * 4), rd);
    end
    // x31 holds last word + 1, step back k words but stay ahead of i
    if (k > prog_words - 2 - i) begin
      k = prog_words - 2 - i;
    end
    return enc_i(12'(-4 * k), 5'd31, 3'b000, rd, op_jalr);
  endfunction

  task automatic build_program(input int mode);
    logic [31:0] r;
    int          first;
    prog[0] = enc_u(20'h0, 5'd31, op_lui);
    prog[1] = enc_i(12'd189, 5'd31, 3'b000, 5'd31, op_imm);
    // seed x1..x8
    for (int k = 1; k <= 8; k++) begin
      r = rand_bits(21);
      if (r[20]) begin
        prog[k + 1] = enc_u(r[19:0], 5'(k), op_lui);
      end else begin
        prog[k + 1] = enc_i(r[11:0], 5'd0, 3'b000, 5'(k), op_imm);
      end
    end
    first = 10;
    if (mode == 1) begin
      // fill data words 0..7 before any load
      for (int k = 1; k <= 8; k++) begin
        prog[k + 9] = enc_s(12'(4 * (k - 1)), 5'(k), 5'd0, 3'b010);
      end
      first = 18;
    end
    for (int i = first; i < prog_words - 1; i++) begin
      r = rand_bits(1);
      if ((mode == 1) && r[0]) begin
        prog[i] = mem_inst();
      end else if ((mode == 2) && r[0]) begin
        prog[i] = branch_inst(i);
      end else if ((mode == 3) && r[0]) begin
        prog[i] = jump_inst(i);
      end else begin
        prog[i] = alu_inst();
      end
    end
    // park on a self loop
    prog[prog_words - 1] = enc_j(21'd0, 5'd0);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic reg_form, input logic [31:0] a,
                                          input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'b000:  return (alt && reg_form) ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes the word at m_pc and updates the reference state
  task automatic model_step(output retire_t exp);
    logic [31:0] w;
    inst_u       u;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] word;
    logic [7:0]  lane;
    logic [2:0]  f3;
    logic [31:0] res;
    logic [31:0] next;
    logic        wr;
    logic        taken;
    w = prog[m_pc[7:2]];
    u = w;
    f3 = u.r_fmt.funct3;
    a = m_regs[u.r_fmt.rs1];
    b = m_regs[u.r_fmt.rs2];
    imm_i = {{20{w[31]}}, w[31:20]};
    res = '0;
    wr = 1'b0;
    taken = 1'b0;
    next = m_pc + 32'd4;
    case (u.r_fmt.opcode)
      op_reg: begin
        wr = 1'b1;
        res = alu_ref(f3, w[30], 1'b1, a, b);
      end
      op_imm: begin
        wr = 1'b1;
        res = alu_ref(f3, w[30], 1'b0, a, imm_i);
      end
      op_lui: begin
        wr = 1'b1;
        res = {w[31:12], 12'b0};
      end
      op_auipc: begin
        wr = 1'b1;
        res = m_pc + {w[31:12], 12'b0};
      end
      op_load: begin
        wr = 1'b1;
        addr = a + imm_i;
        word = m_mem[addr[7:2]];
        lane = word[{addr[1:0], 3'b000} +: 8];
        case (f3)
          3'b000:  res = {{24{lane[7]}}, lane};
          3'b100:  res = {24'b0, lane};
          default: res = word;
        endcase
      end
      op_store: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        if (f3 == 3'b000) begin
          m_mem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
        end else begin
          m_mem[addr[7:2]] = b;
        end
      end
      op_branch: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      op_jal: begin
        wr = 1'b1;
        res = m_pc + 32'd4;
        next = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      op_jalr: begin
        wr = 1'b1;
        res = m_pc + 32'd4;
        next = (a + imm_i) & ~32'd1;
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    exp.valid = 1'b1;
    exp.pc = m_pc;
    exp.rd = u.r_fmt.rd;
    // x0 keeps zero
    exp.reg_write = wr && (u.r_fmt.rd != 5'd0);
    exp.wd = res;
    exp.next_pc = next;
    if (exp.reg_write) begin
      m_regs[u.r_fmt.rd] = res;
    end
    m_pc = next;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_retire(input retire_t exp);
    check_value("retire valid", 32'(retire.valid), 32'(exp.valid));
    check_value("retire pc", retire.pc, exp.pc);
    check_value("retire next_pc", retire.next_pc, exp.next_pc);
    check_value("retire reg_write", 32'(retire.reg_write), 32'(exp.reg_write));
    if (exp.reg_write) begin
      check_value("retire rd", 32'(retire.rd), 32'(exp.rd));
      check_value("retire wd", retire.wd, exp.wd);
    end
  endtask

  task automatic run_test(input int mode, input string name);
    retire_t exp;
    bit      done;
    test_errors = 0;
    build_program(mode);
    // core and model leave reset together
    @(negedge clk);
    arst_n = 1'b0;
    run = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = '0;
    // pc parked at zero during the load
    for (int i = 0; i < prog_words; i++) begin
      load_en = 1'b1;
      load_addr = 6'(i);
      load_data = prog[i];
      #(period / 4);
      check_value("pc while loading", retire.pc, 32'd0);
      @(negedge clk);
    end
    load_en = 1'b0;
    run = 1'b1;
    done = 1'b0;
    // forward-only control flow always reaches the final word
    while (!done) begin
      #(period / 4);
      model_step(exp);
      check_retire(exp);
      done = (exp.pc == final_pc);
      @(negedge clk);
    end
    run = 1'b0;
    repeat (3) begin
      #(period / 4);
      check_value("pc on hold", retire.pc, final_pc);
      check_value("valid on hold", 32'(retire.valid), 32'd0);
      @(negedge clk);
    end
    $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
  endtask

  // hard stop in case a test never reaches its end
  initial begin
    #((num_tests * test_cycles + 20) * period);
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    lfsr = seed;
    errors = 0;
    checks = 0;
    test_errors = 0;
    run_test(0, "alu");
    run_test(1, "load_store");
    run_test(2, "branch");
    run_test(3, "jump");
    $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
